// File: Makefile
TOP := tb_basic_organ

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

// File: src.f
src/organ_pkg.sv
src/tick_divider.sv
src/tone_generator.sv
src/key_conditioner.sv
src/speed_register.sv
src/hex_display.sv
src/basic_organ.sv
verification/tb_basic_organ.sv

// File: src/basic_organ.sv
`timescale 1ns/1ps

module basic_organ #(
  parameter int tick_div     = organ_pkg::DEFAULT_TICK_DIV,
  parameter int repeat_ticks = organ_pkg::DEFAULT_REPEAT_TICKS,
  parameter int refresh_div  = organ_pkg::DEFAULT_REFRESH_DIV
) (
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  logic [3:0]  sw,
  input  logic [2:0]  key_n,
  output logic        tone_out,
  output logic [7:0]  audio_sample,
  output logic [15:0] sample_count,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  import organ_pkg::*;

  logic    scan_tick;
  logic    refresh_tick;
  logic    up_pulse;
  logic    down_pulse;
  logic    reset_level;
  note_e   note;
  sample_t sample;
  count_t  count;
  seg_t    hex [NUM_DIGITS];

  // sw[3:1] picks the note, sw[0] enables it
  assign note = note_e'(sw[3:1]);

  // ==========================================================================
  // Tone path
  // ==========================================================================

  tone_generator u_tone (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note         (note),
    .tone_en      (sw[0]),
    .tone_out     (tone_out),
    .audio_sample (sample)
  );

  assign audio_sample = sample;

  // ==========================================================================
  // Speed control and display
  // ==========================================================================

  tick_divider #(.div(tick_div)) u_scan_tick (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (scan_tick)
  );

  tick_divider #(.div(refresh_div)) u_refresh_tick (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (refresh_tick)
  );

  key_conditioner #(.repeat_ticks(repeat_ticks)) u_keys (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .scan_tick   (scan_tick),
    .key_n       (key_n),
    .up_pulse    (up_pulse),
    .down_pulse  (down_pulse),
    .reset_level (reset_level)
  );

  speed_register u_speed (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .up_pulse     (up_pulse),
    .down_pulse   (down_pulse),
    .reset_level  (reset_level),
    .sample_count (count)
  );

  hex_display u_display (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .refresh_tick (refresh_tick),
    .sample_count (count),
    .hex          (hex)
  );

  assign sample_count = count;

  assign hex0 = hex[0];
  assign hex1 = hex[1];
  assign hex2 = hex[2];
  assign hex3 = hex[3];
  assign hex4 = hex[4];
  assign hex5 = hex[5];

endmodule

// File: src/hex_display.sv
`timescale 1ns/1ps

module hex_display (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic              refresh_tick,
  input  organ_pkg::count_t sample_count,
  output organ_pkg::seg_t   hex [organ_pkg::NUM_DIGITS]
);

  import organ_pkg::*;

  logic [DISPLAY_W-1:0] shown;

  // ==========================================================================
  // Refresh latch
  // ==========================================================================

  // Holds the value steady between slow refresh ticks
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      shown <= '0;
    end
    else if (refresh_tick)
    begin
      shown <= DISPLAY_W'(sample_count);
    end
  end

  // ==========================================================================
  // Digit decoders
  // ==========================================================================

  // Digit 0 is the least significant nibble
  always_comb
  begin
    for (int i = 0; i < NUM_DIGITS; i++)
    begin
      hex[i] = HEX_SEGMENTS[shown[4*i +: 4]];
    end
  end

endmodule

// File: src/key_conditioner.sv
`timescale 1ns/1ps

module key_conditioner #(
  parameter int repeat_ticks = organ_pkg::DEFAULT_REPEAT_TICKS
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic       scan_tick,
  input  logic [2:0] key_n,
  output logic       up_pulse,
  output logic       down_pulse,
  output logic       reset_level
);

  localparam int CNT_W = (repeat_ticks > 1) ? $clog2(repeat_ticks + 1) : 1;

  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] rep_cnt;
  logic             rep_wrap;

  // ==========================================================================
  // Key synchronizers
  // ==========================================================================

  // Keys are active low, held state is 1 after the flops
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
    end
  end

  assign reset_level = key_sync[2];

  // ==========================================================================
  // Repeat rate
  // ==========================================================================

  // Counter reaching repeat_ticks marks a step slot
  assign rep_wrap = (rep_cnt + 1'b1) == CNT_W'(repeat_ticks);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rep_cnt    <= '0;
      up_pulse   <= 1'b0;
      down_pulse <= 1'b0;
    end
    else
    begin
      up_pulse   <= 1'b0;
      down_pulse <= 1'b0;
      if (scan_tick)
      begin
        if (rep_wrap)
        begin
          rep_cnt    <= '0;
          up_pulse   <= key_sync[0];
          down_pulse <= key_sync[1];
        end
        else
        begin
          rep_cnt <= rep_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: src/organ_pkg.sv
package organ_pkg;

  // ==========================================================================
  // Tone section
  // ==========================================================================

  // Switch code order, Do (523 Hz) up to Do2 (1046 Hz)
  typedef enum logic [2:0] {
    DO,
    RE,
    MI,
    FA,
    SO,
    LA,
    SI,
    DO2
  } note_e;

  // Half periods in 50 MHz cycles
  localparam logic [31:0] tone_half_period [8] = '{
    32'd47800, 32'd42590, 32'd37936, 32'd35817,
    32'd31929, 32'd28409, 32'd25329, 32'd23900
  };

  typedef logic signed [7:0] sample_t;

  // ==========================================================================
  // Speed control and display
  // ==========================================================================

  typedef logic signed [15:0] speed_t;
  typedef logic [15:0] count_t;

  localparam speed_t SPEED_STEP = 16'sd100;
  localparam count_t DEFAULT_SAMPLE_COUNT = 16'd12499;

  localparam int NUM_DIGITS = 6;
  localparam int DISPLAY_W = 4 * NUM_DIGITS;

  // Segments gfedcba, a lit segment is 0
  typedef logic [6:0] seg_t;

  localparam seg_t HEX_SEGMENTS [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  // 1 kHz key scan, 10 steps per second, 2 Hz refresh
  localparam int DEFAULT_TICK_DIV = 50000;
  localparam int DEFAULT_REPEAT_TICKS = 100;
  localparam int DEFAULT_REFRESH_DIV = 25000000;

endpackage

// File: src/speed_register.sv
`timescale 1ns/1ps

module speed_register (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic              up_pulse,
  input  logic              down_pulse,
  input  logic              reset_level,
  output organ_pkg::count_t sample_count
);

  import organ_pkg::*;

  speed_t speed;

  // Signed speed accumulator, opposite steps cancel
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || reset_level)
    begin
      speed <= '0;
    end
    else if (up_pulse && !down_pulse)
    begin
      speed <= speed + SPEED_STEP;
    end
    else if (down_pulse && !up_pulse)
    begin
      speed <= speed - SPEED_STEP;
    end
  end

  // Scope sampling count, wraps at 16 bits
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sample_count <= DEFAULT_SAMPLE_COUNT;
    end
    else
    begin
      sample_count <= DEFAULT_SAMPLE_COUNT + count_t'(speed);
    end
  end

endmodule

// File: src/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
  parameter int div = organ_pkg::DEFAULT_TICK_DIV
) (
  input  logic CLK_50M,
  input  logic rst_n,
  output logic tick
);

  localparam int CNT_W = (div > 1) ? $clog2(div) : 1;

  logic [CNT_W-1:0] cnt;

  // Free-running count, strobe on the last cycle of each period
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      tick <= 1'b0;
    end
    else if (cnt == CNT_W'(div - 1))
    begin
      cnt  <= '0;
      tick <= 1'b1;
    end
    else
    begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

// File: src/tone_generator.sv
`timescale 1ns/1ps

module tone_generator (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  organ_pkg::note_e  note,
  input  logic              tone_en,
  output logic              tone_out,
  output organ_pkg::sample_t audio_sample
);

  import organ_pkg::*;

  logic [31:0] half_period;
  logic [31:0] cnt;
  note_e       note_q;
  logic        wave;

  assign half_period = tone_half_period[note];

  // ==========================================================================
  // Half-period counter and square wave
  // ==========================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cnt    <= '0;
      note_q <= DO;
      wave   <= 1'b0;
    end
    else
    begin
      note_q <= note;
      if (note != note_q)
      begin
        // New note selected, start a fresh half period
        cnt <= '0;
      end
      else if (cnt == half_period - 32'd1)
      begin
        cnt  <= '0;
        wave <= ~wave;
      end
      else
      begin
        cnt <= cnt + 32'd1;
      end
    end
  end

  // Gated output and its signed sample
  assign tone_out     = wave & tone_en;
  assign audio_sample = tone_out ? 8'sh7F : 8'sh80;

endmodule

// File: verification/tb_basic_organ.sv
`timescale 1ns/1ps

module tb_basic_organ;

  import organ_pkg::*;

  localparam int TICK_DIV = 10;
  localparam int REPEAT_TICKS = 4;
  localparam int REFRESH_DIV = 50;
  localparam int CYCLE_LIMIT = 2000000;

  typedef enum logic [1:0] {M_IDLE, M_UP, M_DOWN, M_RESET} key_mode_e;

  logic        CLK_50M;
  logic        rst_n;
  logic [3:0]  sw;
  logic [2:0]  key_n;
  logic        tone_out;
  logic [7:0]  audio_sample;
  logic [15:0] sample_count;
  logic [6:0]  hex_out [6];

  logic [31:0] lfsr = 32'h92b35fcd;
  key_mode_e   mode;
  int          errors = 0;
  int          cycles = 0;

  // Reference model state
  logic [3:0]  sw_q = '0;
  logic        last_tone = 1'b0;
  logic        run_valid = 1'b0;
  logic [31:0] run_len = '0;
  logic [15:0] count_q = '0;
  logic [15:0] disp_model = '0;
  key_mode_e   mode_q = M_IDLE;
  logic        gap_valid = 1'b0;
  logic        reset_armed = 1'b0;
  int          step_gap = 0;
  int          reset_held = 0;
  int          ref_cnt = 0;
  int          tone_checks = 0;
  int          step_count = 0;
  logic        stepped;

  assign stepped = sample_count != count_q;

  basic_organ #(
    .tick_div     (TICK_DIV),
    .repeat_ticks (REPEAT_TICKS),
    .refresh_div  (REFRESH_DIV)
  ) dut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sw           (sw),
    .key_n        (key_n),
    .tone_out     (tone_out),
    .audio_sample (audio_sample),
    .sample_count (sample_count),
    .hex0         (hex_out[0]),
    .hex1         (hex_out[1]),
    .hex2         (hex_out[2]),
    .hex3         (hex_out[3]),
    .hex4         (hex_out[4]),
    .hex5         (hex_out[5])
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h80200003;
    return n;
  endfunction

  task automatic rand_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [6:0] digit_seg(input logic [15:0] value, input int digit);
    logic [23:0] wide;
    wide = {8'h00, value};
    return HEX_SEGMENTS[wide[4*digit +: 4]];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors = errors + 1;
    $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
  endtask

  task automatic report_failure(input string what);
    errors = errors + 1;
    $display("ERROR: %s", what);
  endtask

  task automatic wait_tone_checks(input int n);
    int target;
    target = tone_checks + n;
    while (tone_checks < target)
      @(posedge CLK_50M);
  endtask

  // Press the masked keys for a number of cycles, then let the pulses drain
  task automatic hold_keys(input logic [2:0] press, input int len, input key_mode_e m);
    @(posedge CLK_50M);
    mode  <= m;
    key_n <= ~press;
    repeat (len) @(posedge CLK_50M);
    key_n <= 3'b111;
    repeat (20) @(posedge CLK_50M);
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================

  always @(posedge CLK_50M)
  begin
    sw_q      <= sw;
    last_tone <= tone_out;
    count_q   <= sample_count;
    mode_q    <= mode;

    // Any switch change voids the half-period run of tone_out
    if (sw != sw_q)
      run_valid <= 1'b0;
    else if (tone_out != last_tone)
    begin
      run_valid   <= 1'b1;
      tone_checks <= tone_checks + (run_valid ? 1 : 0);
    end
    run_len <= (sw != sw_q || tone_out != last_tone) ? 32'd1 : run_len + 32'd1;

    // Spacing of speed steps within one key test
    if (mode != mode_q)
      gap_valid <= 1'b0;
    else if (stepped)
    begin
      gap_valid  <= 1'b1;
      step_count <= step_count + ((mode == M_UP || mode == M_DOWN) ? 1 : 0);
    end
    step_gap <= (mode != mode_q || stepped) ? 1 : step_gap + 1;

    // Sync, speed clear and count register need a few cycles
    reset_held  <= (mode != M_RESET) ? 0 : reset_held + (key_n[2] ? 0 : 1);
    reset_armed <= (mode == M_RESET) && (reset_armed || reset_held >= 5);

    // Display latch loads on the cycle after each refresh tick
    if (!rst_n)
    begin
      ref_cnt    <= 0;
      disp_model <= '0;
    end
    else if (ref_cnt == REFRESH_DIV)
    begin
      ref_cnt    <= 1;
      disp_model <= sample_count;
    end
    else
      ref_cnt <= ref_cnt + 1;
  end

  // ==========================================================================
  // Checks
  // ==========================================================================

  tone_period_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (run_valid && sw == sw_q && tone_out != last_tone)
      |-> run_len == tone_half_period[sw[3:1]])
    else report_mismatch("tone_period", tone_half_period[$sampled(sw[3:1])],
                         $sampled(run_len));

  sample_level_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    audio_sample == (tone_out ? 8'h7F : 8'h80))
    else report_mismatch("audio_sample", $sampled(tone_out) ? 32'h7F : 32'h80,
                         32'($sampled(audio_sample)));

  tone_off_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    !sw[0] |-> !tone_out)
    else report_mismatch("tone_disabled", 32'd0, 32'($sampled(tone_out)));

  step_up_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (mode == M_UP && mode_q == M_UP && stepped) |-> sample_count == count_q + 16'd100)
    else report_mismatch("speed_up", 32'(16'($sampled(count_q) + 16'd100)),
                         32'($sampled(sample_count)));

  step_down_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (mode == M_DOWN && mode_q == M_DOWN && stepped) |-> sample_count == count_q - 16'd100)
    else report_mismatch("speed_down", 32'(16'($sampled(count_q) - 16'd100)),
                         32'($sampled(sample_count)));

  step_gap_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    ((mode == M_UP || mode == M_DOWN) && mode == mode_q && stepped && gap_valid)
      |-> step_gap >= TICK_DIV * REPEAT_TICKS)
    else report_failure($sformatf("speed steps came only %0d cycles apart",
                                  $sampled(step_gap)));

  reset_value_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (mode == M_RESET && reset_armed) |-> sample_count == 16'd12499)
    else report_mismatch("speed_reset", 32'd12499, 32'($sampled(sample_count)));

  for (genvar d = 0; d < NUM_DIGITS; d++)
  begin : g_digit
    display_check: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      hex_out[d] == digit_seg(disp_model, d))
      else report_mismatch($sformatf("display_digit%0d", d),
                           32'(digit_seg($sampled(disp_model), d)),
                           32'($sampled(hex_out[d])));
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial
  begin
    int start;
    int len;
    int steps_before;
    rst_n = 1'b0;
    sw    = 4'b0000;
    key_n = 3'b111;
    mode  = M_IDLE;
    repeat (2) @(posedge CLK_50M);
    rst_n <= 1'b1;
    @(posedge CLK_50M);
    assert (tone_out == 1'b0)
      else report_mismatch("reset_tone", 32'd0, 32'(tone_out));
    assert (sample_count == 16'd12499)
      else report_mismatch("reset_count", 32'd12499, 32'(sample_count));

    // Every note in turn from a random start
    rand_bits(3, start);
    for (int i = 0; i < 8; i++)
    begin
      @(posedge CLK_50M);
      sw <= {3'((start + i) % 8), 1'b1};
      @(posedge CLK_50M);
      wait_tone_checks(2);
    end

    // Switch off while the wave is high so the gate has work to do
    while (tone_out !== 1'b1)
      @(posedge CLK_50M);

    // Tone switched off on a random note
    rand_bits(3, start);
    rand_bits(10, len);
    @(posedge CLK_50M);
    sw <= {3'(start), 1'b0};
    repeat (200 + len) @(posedge CLK_50M);

    steps_before = step_count;
    rand_bits(8, len);
    hold_keys(3'b001, 100 + len, M_UP);
    assert (step_count > steps_before)
      else report_failure("up key held but sample_count never stepped");

    // Long enough to wrap the count below zero
    steps_before = step_count;
    rand_bits(10, len);
    hold_keys(3'b010, 6000 + len, M_DOWN);
    assert (step_count > steps_before)
      else report_failure("down key held but sample_count never stepped");

    rand_bits(4, len);
    hold_keys(3'b100, 8 + len, M_RESET);
    rand_bits(6, len);
    hold_keys(3'b001, 60 + len, M_UP);

    @(posedge CLK_50M);
    mode <= M_IDLE;
    repeat (2 * REFRESH_DIV) @(posedge CLK_50M);
    $display("Summary: %0d errors, %0d tone periods checked, %0d speed steps seen",
             errors, tone_checks, step_count);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Eight notes of a few half periods each plus the key and display tests
  always @(posedge CLK_50M)
  begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT)
    begin
      $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Summary: %0d errors before the timeout", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule
